/* dv/cache_tb.sv */
// cache_tb: clock/reset, LFSR stimulus, MESI/LRU reference model, result checks, cycle timeout
`timescale 1ns/1ns
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int SETS        = 16;        // cache_top defaults
    localparam int IWAYS       = 4;
    localparam int DWAYS       = 8;
    localparam int NUM_CMDS    = 16 + 6 + 16 + 7 + 9 + 400;
    localparam int CYCLE_LIMIT = 10 * NUM_CMDS * 6 + 20 * SETS;

    logic    clk;
    logic    reset_i;
    logic    req_i;
    cmd_t    cmd_i;
    logic    ack_o;
    result_t result_o;

    logic [15:0]      lfsr_q;
    int               cycle_cnt, pass_cnt, fail_cnt, cmd_count, cmd_start, fail_start;
    string            test_name;
    result_t          last_res;                 // DUT result of the latest command
    logic [TAG_W-1:0] m_tag  [2][SETS][DWAYS];  // [0] icache, [1] dcache
    mesi_e            m_mesi [2][SETS][DWAYS];
    int               m_age  [2][SETS][DWAYS];

    cache_top UUT (
        .clk(clk), .reset_i(reset_i), .req_i(req_i), .cmd_i(cmd_i),
        .ack_o(ack_o), .result_o(result_o)
    );

    always #10 clk = ~clk;                      // 20 ns period

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the req/ack handshake stalled", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // x^16+x^14+x^13+x^11+1, one step per bit handed out
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[14:0], fb};
        end
        return r;
    endfunction

    function automatic logic [TAG_W-1:0] tag_at(input int i);
        return TAG_W'(32'h3A5C0 + i * 32'h1F3);  // spread-out tags, index 0..5 is the pool
    endfunction

    task automatic model_reset();
        for (int c = 0; c < 2; c++)
            for (int s = 0; s < SETS; s++)
                for (int w = 0; w < DWAYS; w++) begin
                    m_tag[c][s][w]  = '0;
                    m_mesi[c][s][w] = INVALID;
                    m_age[c][s][w]  = w;        // age follows way index when empty
                end
    endtask

    // expected result and new model state for one command
    task automatic model_apply(input cmd_t c, output result_t e);
        int               ci, n, s, w, hw, vw;
        logic [TAG_W-1:0] tag;
        logic             hit, touch;
        mesi_e            mb, ma;
        bus_op_e          bus;
        e = '0;
        if (c.op == OP_CLEAR) begin
            model_reset();
        end else begin
            ci  = (c.op == OP_IFETCH) ? 0 : 1;
            n   = (c.op == OP_IFETCH) ? IWAYS : DWAYS;
            s   = int'(c.addr[9:6]);            // [31:10] tag, [9:6] set
            tag = c.addr[31:10];
            hit = 1'b0;
            hw  = 0;
            vw  = -1;
            for (int i = 0; i < n; i++) begin
                if (m_mesi[ci][s][i] != INVALID && m_tag[ci][s][i] == tag) begin
                    hit = 1'b1;
                    hw  = i;
                end
                if (vw < 0 && m_mesi[ci][s][i] == INVALID) vw = i;  // lowest free way
            end
            if (vw < 0)
                for (int i = 0; i < n; i++) if (m_age[ci][s][i] == 0) vw = i;  // LRU
            w     = hit ? hw : vw;
            mb    = m_mesi[ci][s][w];
            ma    = mb;
            bus   = BUS_NONE;
            touch = 1'b0;
            case (c.op)
                OP_DREAD, OP_IFETCH: begin
                    touch = 1'b1;
                    if (!hit) begin
                        ma  = EXCLUSIVE;
                        bus = BUS_READ;
                    end
                end
                OP_DWRITE: begin
                    touch = 1'b1;
                    ma    = MODIFIED;
                    bus   = !hit ? BUS_RFO : (mb == SHARED) ? BUS_INVAL : BUS_NONE;
                end
                OP_L2_INVAL: if (hit) ma = INVALID;
                OP_SNOOP_RD: if (hit) begin
                    ma  = SHARED;
                    bus = (mb == MODIFIED) ? BUS_WRITEBACK : BUS_NONE;
                end
                default: ;
            endcase
            e.hit         = hit;
            e.icache      = (ci == 0);
            e.way         = 3'(w);
            e.mesi_before = mb;
            e.mesi_after  = ma;
            e.bus_op      = bus;
            e.evict_wb    = touch && !hit && (mb == MODIFIED);
            e.evict_tag   = e.evict_wb ? m_tag[ci][s][w] : '0;
            if (touch) begin
                for (int i = 0; i < n; i++)
                    if (m_age[ci][s][i] > m_age[ci][s][w]) m_age[ci][s][i]--;
                m_age[ci][s][w] = n - 1;        // most recently used
                if (!hit) m_tag[ci][s][w] = tag;
            end
            m_mesi[ci][s][w] = ma;
        end
    endtask

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, field, exp, got);
        end
    endtask

    // one four-phase transaction, entered and left 2 ns after a rising edge
    task automatic run_cmd(input opcode_e op, input logic [TAG_W-1:0] tag,
                           input logic [3:0] set, input int hold);
        cmd_t        c;
        result_t     e;
        logic [15:0] off;
        int          edges;
        off    = rand_bits(6);
        c.op   = op;
        c.addr = {tag, set, off[5:0]};
        model_apply(c, e);
        cmd_i  = c;
        req_i  = 1'b1;
        @(posedge clk);
        #2;
        edges = 1;
        while (!ack_o) begin
            @(posedge clk);
            #2;
            edges++;
        end
        compare_field("latency", (op == OP_CLEAR) ? SETS + 1 : 3, edges - 1);
        last_res = result_o;
        compare_field("hit", 32'(e.hit), 32'(result_o.hit));
        compare_field("icache", 32'(e.icache), 32'(result_o.icache));
        compare_field("way", 32'(e.way), 32'(result_o.way));
        compare_field("mesi_before", 32'(e.mesi_before), 32'(result_o.mesi_before));
        compare_field("mesi_after", 32'(e.mesi_after), 32'(result_o.mesi_after));
        compare_field("bus_op", 32'(e.bus_op), 32'(result_o.bus_op));
        compare_field("evict_wb", 32'(e.evict_wb), 32'(result_o.evict_wb));
        compare_field("evict_tag", 32'(e.evict_tag), 32'(result_o.evict_tag));
        repeat (hold) begin                     // back-pressure, ack must stay up
            @(posedge clk);
            #2;
            compare_field("ack_held", 1, 32'(ack_o));
        end
        req_i = 1'b0;
        @(posedge clk);
        #2;
        edges = 1;
        while (ack_o) begin
            @(posedge clk);
            #2;
            edges++;
        end
        compare_field("ack_drop", 1, edges);   // ack falls on the first edge seeing req low
        cmd_count++;
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        cmd_start  = cmd_count;
        fail_start = fail_cnt;
    endtask

    task automatic end_test();
        $display("test %-16s done: %0d commands, %0d mismatches", test_name,
                 cmd_count - cmd_start, fail_cnt - fail_start);
    endtask

    initial begin
        opcode_e     op;
        logic [15:0] r;
        clk       = 1'b0;
        reset_i   = 1'b1;
        req_i     = 1'b0;
        cmd_i     = '0;
        lfsr_q    = 16'd49415;
        cycle_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cmd_count = 0;
        last_res  = '0;
        model_reset();
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;

        begin_test("read_fill");                // both caches, set 5
        for (int i = 0; i < IWAYS; i++) run_cmd(OP_IFETCH, tag_at(i), 4'd5, 0);
        for (int i = 0; i < IWAYS; i++) begin
            run_cmd(OP_IFETCH, tag_at(i), 4'd5, 0);
            compare_field("repeat_way", i, 32'(last_res.way));
        end
        for (int i = 0; i < 4; i++) run_cmd(OP_DREAD, tag_at(i), 4'd5, 0);
        for (int i = 0; i < 4; i++) run_cmd(OP_DREAD, tag_at(i), 4'd5, 0);
        end_test();

        begin_test("write_states");             // E->M, M->M, miss RFO, S->M
        run_cmd(OP_DREAD, tag_at(0), 4'd7, 0);
        run_cmd(OP_DWRITE, tag_at(0), 4'd7, 0);
        run_cmd(OP_DWRITE, tag_at(0), 4'd7, 0);
        run_cmd(OP_DWRITE, tag_at(1), 4'd7, 0);
        run_cmd(OP_SNOOP_RD, tag_at(1), 4'd7, 0);
        run_cmd(OP_DWRITE, tag_at(1), 4'd7, 0);
        compare_field("shared_write_bus", 32'(BUS_INVAL), 32'(last_res.bus_op));
        end_test();

        begin_test("lru_evict");
        for (int i = 0; i < 6; i++) begin
            run_cmd(OP_IFETCH, tag_at(i), 4'd9, 0);
            if (i >= IWAYS) compare_field("lru_way", i - IWAYS, 32'(last_res.way));
        end
        for (int i = 0; i < 10; i++) begin
            run_cmd(OP_DWRITE, tag_at(i), 4'd9, 0);
            if (i >= DWAYS) begin
                compare_field("dirty_evict", 1, 32'(last_res.evict_wb));
                compare_field("evicted_tag", 32'(tag_at(i - DWAYS)), 32'(last_res.evict_tag));
            end
        end
        end_test();

        begin_test("l2_commands");              // set 11
        run_cmd(OP_DREAD, tag_at(0), 4'd11, 0);
        run_cmd(OP_DWRITE, tag_at(1), 4'd11, 0);
        run_cmd(OP_L2_INVAL, tag_at(0), 4'd11, 0);
        run_cmd(OP_SNOOP_RD, tag_at(1), 4'd11, 0);
        compare_field("snoop_mod_bus", 32'(BUS_WRITEBACK), 32'(last_res.bus_op));
        run_cmd(OP_SNOOP_RD, tag_at(2), 4'd11, 0);
        run_cmd(OP_L2_INVAL, tag_at(2), 4'd11, 0);
        run_cmd(OP_DREAD, tag_at(0), 4'd11, 0);   // refills the invalidated way 0
        compare_field("refill_way", 0, 32'(last_res.way));
        end_test();

        begin_test("clear_handshake");
        run_cmd(OP_CLEAR, '0, 4'd0, 2);
        for (int i = 0; i < 4; i++) begin
            r = rand_bits(3);
            run_cmd(OP_IFETCH, tag_at(i), 4'd5, int'(r[2:0]));
            compare_field("after_clear_hit", 0, 32'(last_res.hit));
            r = rand_bits(3);
            run_cmd(OP_DREAD, tag_at(i), 4'd5, int'(r[2:0]));
            compare_field("after_clear_hit", 0, 32'(last_res.hit));
        end
        end_test();

        begin_test("random_mix");               // pool of 6 tags over sets 3 and 12
        for (int k = 0; k < 400; k++) begin
            r = rand_bits(3);
            case (r[2:0])
                3'd0, 3'd1: op = OP_DREAD;
                3'd2, 3'd3: op = OP_DWRITE;
                3'd4, 3'd5: op = OP_IFETCH;
                3'd6:       op = OP_L2_INVAL;
                default:    op = OP_SNOOP_RD;
            endcase
            r = rand_bits(3);
            run_cmd(op, tag_at(int'(r[2:0]) % 6), rand_bits(1) ? 4'd3 : 4'd12,
                    int'(rand_bits(2)));
        end
        end_test();

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/tag_array.sv
verilog/way_select.sv
verilog/state_update.sv
verilog/cache_top.sv
dv/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f files.f -Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* verilog/cache_ctrl.sv */
// cache_ctrl: four-phase req/ack FSM, read/update/write sequencing and the clear walk
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    req_i,
    input  cache_pkg::cmd_t         cmd_i,
    output logic                    ack_o,
    output logic                    rd_en_o,
    output logic                    wr_en_i_o,
    output logic                    wr_en_d_o,
    output logic [$clog2(SETS)-1:0] set_o,
    output logic                    clear_o,
    output cache_pkg::cmd_t         cmd_q_o
);
    import cache_pkg::*;

    localparam int SET_W = $clog2(SETS);

    typedef enum logic [2:0] {
        IDLE,
        READ,       // arrays register the set
        UPDATE,     // selectors and updater work on it
        WRITE,      // new set goes back
        CLEAR,      // one set of both arrays per cycle
        DONE        // ack held until req drops
    } state_e;

    state_e           state_q, state_d;
    cmd_t             cmd_q;
    logic [SET_W-1:0] clr_cnt;
    logic             is_clear;
    logic             is_ifetch;
    logic             clr_last;

    // address split: [31:10] tag | [9:6] set | [5:0] byte offset
    // tag is fixed to the top TAG_W bits, set sits just above the offset
    assign is_clear  = (cmd_q.op == OP_CLEAR);
    assign is_ifetch = (cmd_q.op == OP_IFETCH);  // everything else targets the dcache
    assign clr_last  = (clr_cnt == SET_W'(SETS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_i) state_d = READ;
            READ:    state_d = is_clear ? CLEAR : UPDATE;
            UPDATE:  state_d = WRITE;
            WRITE:   state_d = DONE;
            CLEAR:   if (clr_last) state_d = DONE;
            DONE:    if (!req_i) state_d = IDLE;   // four-phase return to zero
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            clr_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == READ) begin
                clr_cnt <= '0;                  // walk always starts at set 0
            end else if (state_q == CLEAR) begin
                clr_cnt <= clr_cnt + 1'b1;
            end
        end
    end

    // command is stable while req is high, take it on acceptance
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_i) begin
            cmd_q <= cmd_i;
        end
    end

    assign ack_o     = (state_q == DONE);
    assign rd_en_o   = (state_q == READ);
    assign clear_o   = (state_q == CLEAR);
    assign wr_en_i_o = (state_q == WRITE && is_ifetch) || clear_o;
    assign wr_en_d_o = (state_q == WRITE && !is_ifetch) || clear_o;
    assign set_o     = clear_o ? clr_cnt : cmd_q.addr[OFFSET_W +: SET_W];
    assign cmd_q_o   = cmd_q;

    // no array write may start outside a command
    a_no_wr_idle: assert property (@(posedge clk) disable iff (reset_i)
        (state_q == IDLE) |-> !(wr_en_i_o || wr_en_d_o))
        else $error("cache_ctrl: array write while idle");

    // source must still be holding req on the edge that raises ack
    a_ack_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("cache_ctrl: ack raised without a pending req");

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
// cache_pkg: address widths, MESI/opcode/bus enums, entry/command/result structs, field helpers
`default_nettype none

package cache_pkg;

    localparam int ADDR_W   = 32;           // trace address width
    localparam int OFFSET_W = 6;            // 64-byte lines
    localparam int TAG_W    = 22;           // ADDR_W - OFFSET_W - log2(16 sets)

    // line state, INVALID must stay zero so a cleared entry is invalid
    typedef enum logic [1:0] {
        INVALID   = 2'd0,
        SHARED    = 2'd1,
        EXCLUSIVE = 2'd2,
        MODIFIED  = 2'd3
    } mesi_e;

    // trace opcodes as they appear in the command file
    typedef enum logic [3:0] {
        OP_DREAD    = 4'd0,
        OP_DWRITE   = 4'd1,
        OP_IFETCH   = 4'd2,
        OP_L2_INVAL = 4'd3,
        OP_SNOOP_RD = 4'd4,
        OP_CLEAR    = 4'd8
    } opcode_e;

    typedef enum logic [2:0] {
        BUS_NONE      = 3'd0,
        BUS_READ      = 3'd1,
        BUS_RFO       = 3'd2,               // read for ownership
        BUS_INVAL     = 3'd3,
        BUS_WRITEBACK = 3'd4
    } bus_op_e;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        mesi_e            mesi;
        logic [7:0]       age;              // 0 = least recently used
    } way_entry_t;                          // 32 bits

    typedef struct packed {
        opcode_e           op;
        logic [ADDR_W-1:0] addr;
    } cmd_t;                                // 36 bits

    typedef struct packed {
        logic             hit;
        logic             icache;           // 1 = instruction cache was used
        logic [2:0]       way;
        mesi_e            mesi_before;
        mesi_e            mesi_after;
        bus_op_e          bus_op;
        logic             evict_wb;         // dirty victim leaves the cache
        logic [TAG_W-1:0] evict_tag;
    } result_t;                             // 35 bits

    // age bits needed to order WAYS ways, never less than one
    function automatic int age_bits(input int ways);
        return (ways > 1) ? $clog2(ways) : 1;
    endfunction

    // tag is always the top TAG_W address bits
    function automatic logic [TAG_W-1:0] tag_of(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

endpackage

`default_nettype wire

/* verilog/cache_top.sv */
// cache_top: command port, controller, icache/dcache tag arrays and selectors, state updater
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int SETS  = 16,
    parameter int IWAYS = 4,
    parameter int DWAYS = 8
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               req_i,
    input  cache_pkg::cmd_t    cmd_i,
    output logic               ack_o,
    output cache_pkg::result_t result_o
);
    import cache_pkg::*;

    localparam int SET_W = $clog2(SETS);
    localparam int IW_W  = $clog2(IWAYS);
    localparam int DW_W  = $clog2(DWAYS);

    logic                   rd_en;
    logic                   wr_en_i;        // icache write strobe
    logic                   wr_en_d;        // dcache write strobe
    logic                   clear;
    logic [SET_W-1:0]       set_idx;
    cmd_t                   cmd_q;
    logic [TAG_W-1:0]       cmd_tag;

    way_entry_t [IWAYS-1:0] iset;           // stored icache set
    way_entry_t [DWAYS-1:0] dset;           // stored dcache set
    way_entry_t [DWAYS-1:0] new_set;        // low IWAYS entries feed the icache

    logic                   ihit, dhit;
    logic [IW_W-1:0]        ihit_way, ivictim;
    logic [DW_W-1:0]        dhit_way, dvictim;

    assign cmd_tag = tag_of(cmd_q.addr);

    cache_ctrl #(.SETS(SETS)) u_ctrl (
        .clk(clk), .reset_i(reset_i), .req_i(req_i), .cmd_i(cmd_i),
        .ack_o(ack_o), .rd_en_o(rd_en), .wr_en_i_o(wr_en_i), .wr_en_d_o(wr_en_d),
        .set_o(set_idx), .clear_o(clear), .cmd_q_o(cmd_q)
    );

    tag_array #(.SETS(SETS), .WAYS(IWAYS)) u_iarray (
        .clk(clk), .reset_i(reset_i), .rd_en_i(rd_en), .wr_en_i(wr_en_i),
        .set_i(set_idx), .clear_i(clear), .wdata_i(new_set[IWAYS-1:0]), .rdata_o(iset)
    );

    tag_array #(.SETS(SETS), .WAYS(DWAYS)) u_darray (
        .clk(clk), .reset_i(reset_i), .rd_en_i(rd_en), .wr_en_i(wr_en_d),
        .set_i(set_idx), .clear_i(clear), .wdata_i(new_set), .rdata_o(dset)
    );

    way_select #(.WAYS(IWAYS)) u_isel (
        .set_i(iset), .tag_i(cmd_tag),
        .hit_o(ihit), .hit_way_o(ihit_way), .victim_way_o(ivictim)
    );

    way_select #(.WAYS(DWAYS)) u_dsel (
        .set_i(dset), .tag_i(cmd_tag),
        .hit_o(dhit), .hit_way_o(dhit_way), .victim_way_o(dvictim)
    );

    // read strobe doubles as update enable, set data lands a cycle later
    state_update #(.IWAYS(IWAYS), .DWAYS(DWAYS)) u_update (
        .clk(clk), .reset_i(reset_i), .en_i(rd_en), .cmd_i(cmd_q),
        .iset_i(iset), .dset_i(dset),
        .ihit_i(ihit), .ihit_way_i(ihit_way), .ivictim_i(ivictim),
        .dhit_i(dhit), .dhit_way_i(dhit_way), .dvictim_i(dvictim),
        .new_set_o(new_set), .result_o(result_o)
    );

endmodule

`default_nettype wire

/* verilog/state_update.sv */
// state_update: MESI transition, LRU ages, bus op, eviction report and the registered result
`timescale 1ns/1ns
`default_nettype none

module state_update #(
    parameter int IWAYS = 4,
    parameter int DWAYS = 8
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              en_i,
    input  cache_pkg::cmd_t                   cmd_i,
    input  cache_pkg::way_entry_t [IWAYS-1:0] iset_i,
    input  cache_pkg::way_entry_t [DWAYS-1:0] dset_i,
    input  logic                              ihit_i,
    input  logic [$clog2(IWAYS)-1:0]          ihit_way_i,
    input  logic [$clog2(IWAYS)-1:0]          ivictim_i,
    input  logic                              dhit_i,
    input  logic [$clog2(DWAYS)-1:0]          dhit_way_i,
    input  logic [$clog2(DWAYS)-1:0]          dvictim_i,
    output cache_pkg::way_entry_t [DWAYS-1:0] new_set_o,
    output cache_pkg::result_t                result_o
);
    import cache_pkg::*;

    localparam int DW_W = $clog2(DWAYS);

    logic                   en_q;           // set data valid this cycle
    logic                   ic, hit, touch;
    logic [DW_W-1:0]        way;
    int                     nways;
    way_entry_t [DWAYS-1:0] work;           // selected cache's set, widened
    way_entry_t             old;
    mesi_e                  mesi_new;
    bus_op_e                bus;
    result_t                res;

    always_comb begin
        ic    = (cmd_i.op == OP_IFETCH);
        nways = ic ? IWAYS : DWAYS;
        work  = dset_i;
        if (ic) work[IWAYS-1:0] = iset_i;
        hit   = ic ? ihit_i : dhit_i;
        if (ic) way = DW_W'(hit ? ihit_way_i : ivictim_i);
        else    way = hit ? dhit_way_i : dvictim_i;
        old      = work[way];
        touch    = 1'b0;                    // access that moves the LRU order
        mesi_new = old.mesi;
        bus      = BUS_NONE;
        case (cmd_i.op)
            OP_DREAD, OP_IFETCH: begin
                touch = 1'b1;
                if (!hit) begin
                    mesi_new = EXCLUSIVE;   // no other L1 modelled
                    bus      = BUS_READ;
                end
            end
            OP_DWRITE: begin
                touch    = 1'b1;
                mesi_new = MODIFIED;
                if (!hit)                    bus = BUS_RFO;
                else if (old.mesi == SHARED) bus = BUS_INVAL;
            end
            OP_L2_INVAL: if (hit) mesi_new = INVALID;
            OP_SNOOP_RD: if (hit) begin
                mesi_new = SHARED;
                if (old.mesi == MODIFIED) bus = BUS_WRITEBACK;
            end
            default: ;                      // clear and unknown ops change nothing here
        endcase

        new_set_o = work;
        if (touch) begin
            for (int i = 0; i < DWAYS; i++) begin
                if (i < nways && work[i].age > old.age) new_set_o[i].age = work[i].age - 8'd1;
            end
            new_set_o[way].age = 8'(nways - 1);  // most recently used
            if (!hit) new_set_o[way].tag = tag_of(cmd_i.addr);
        end
        new_set_o[way].mesi = mesi_new;

        // way is the hit way, or the victim on a miss even when nothing is installed
        res.hit         = hit;
        res.icache      = ic;
        res.way         = 3'(way);
        res.mesi_before = old.mesi;
        res.mesi_after  = mesi_new;
        res.bus_op      = bus;
        res.evict_wb    = touch && !hit && (old.mesi == MODIFIED);
        res.evict_tag   = res.evict_wb ? old.tag : '0;
        if (cmd_i.op == OP_CLEAR) res = '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            en_q     <= 1'b0;
            result_o <= '0;
        end else begin
            en_q <= en_i;                   // read strobe, array answers next cycle
            if (en_q) result_o <= res;
        end
    end

endmodule

`default_nettype wire

/* verilog/tag_array.sv */
// tag_array: per-set tag/MESI/age storage, registered set read, whole-set write and clear
`timescale 1ns/1ns
`default_nettype none

module tag_array #(
    parameter int SETS = 16,
    parameter int WAYS = 4
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  rd_en_i,
    input  logic                                  wr_en_i,
    input  logic [$clog2(SETS)-1:0]               set_i,
    input  logic                                  clear_i,
    input  cache_pkg::way_entry_t [WAYS-1:0]      wdata_i,
    output cache_pkg::way_entry_t [WAYS-1:0]      rdata_o
);
    import cache_pkg::*;

    localparam int AW = age_bits(WAYS);

    way_entry_t [WAYS-1:0] mem [SETS];      // one row per set
    way_entry_t [WAYS-1:0] init_set;        // contents after reset or clear
    logic       [WAYS-1:0] seen;            // ages already present in wdata
    logic                  ages_ok;

    // empty set: all invalid, ages ordered by way index
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            init_set[w].tag  = '0;
            init_set[w].mesi = INVALID;
            init_set[w].age  = 8'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < SETS; s++) begin
                mem[s] <= init_set;
            end
        end else if (wr_en_i) begin
            mem[set_i] <= clear_i ? init_set : wdata_i;  // clear ignores wdata
        end
    end

    // read data holds between reads, the updater relies on it in WRITE
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rdata_o <= init_set;
        end else if (rd_en_i) begin
            rdata_o <= mem[set_i];
        end
    end

    // ages of a set must stay a permutation of 0..WAYS-1
    always_comb begin
        seen    = '0;
        ages_ok = 1'b1;
        for (int w = 0; w < WAYS; w++) begin
            if (wdata_i[w].age >= 8'(WAYS)) begin
                ages_ok = 1'b0;                 // out of range
            end else begin
                seen[wdata_i[w].age[AW-1:0]] = 1'b1;
            end
        end
        if (!(&seen)) begin
            ages_ok = 1'b0;                     // some age missing, so one repeats
        end
    end

    a_age_perm: assert property (@(posedge clk) disable iff (reset_i)
        (wr_en_i && !clear_i) |-> ages_ok)
        else $error("tag_array: set %0d written with broken LRU ages", set_i);

endmodule

`default_nettype wire

/* verilog/way_select.sv */
// way_select: tag compare, one-hot hit encode, victim pick (lowest invalid, else age zero)
`timescale 1ns/1ns
`default_nettype none

module way_select #(
    parameter int WAYS = 4
) (
    input  cache_pkg::way_entry_t [WAYS-1:0] set_i,
    input  logic [cache_pkg::TAG_W-1:0]      tag_i,
    output logic                             hit_o,
    output logic [$clog2(WAYS)-1:0]          hit_way_o,
    output logic [$clog2(WAYS)-1:0]          victim_way_o
);
    import cache_pkg::*;

    localparam int AW = age_bits(WAYS);
    localparam int WW = $clog2(WAYS);

    logic [WAYS-1:0] hit_vec;               // valid and tag equal
    logic [WAYS-1:0] inv_vec;               // free ways
    logic [WAYS-1:0] lru_vec;               // age zero

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            inv_vec[w] = (set_i[w].mesi == INVALID);
            hit_vec[w] = !inv_vec[w] && (set_i[w].tag == tag_i);
            lru_vec[w] = (set_i[w].age[AW-1:0] == '0);
        end
    end

    assign hit_o = |hit_vec;

    // one-hot to index, OR of indices is exact when at most one bit is set
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way_o = hit_way_o | WW'(w);
            end
        end
    end

    // lowest invalid way wins, scanned top down so the last match is the lowest
    always_comb begin
        victim_way_o = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (lru_vec[w]) begin
                victim_way_o = WW'(w);
            end
        end
        if (|inv_vec) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (inv_vec[w]) begin
                    victim_way_o = WW'(w);
                end
            end
        end
    end

    // a tag is installed only on a miss, so a set never holds it twice
    a_one_hit: assert final ($onehot0(hit_vec))
        else $error("way_select: tag %h hits more than one way", tag_i);

endmodule

`default_nettype wire
